// File: source/arcade_settings.svh
// Arcade video subsystem constants for clock division, register map and screen size
`ifndef ARCADE_SETTINGS_SVH
`define ARCADE_SETTINGS_SVH

// Pixel clock divider width, one enable every 2**N master clocks
`define ARC_PCLK_DIV_BITS 3

// Start of the register window in the CPU map
`define ARC_REG_BASE 16'h0800

// VRAM byte region, 1024 words of 16 bits
`define ARC_VRAM_BYTES 2048

// First line of vertical blank
`define ARC_VBLANK_LINE 224

`endif

// File: source/arcade_pkg.sv
// Arcade video subsystem shared types for bus, tile map, tile ROM and pixel data
package arcade_pkg;

	// CPU bus
	typedef logic [15:0] cpu_addr_t;    // Byte address
	typedef logic [7:0]  cpu_data_t;    // Data byte

	// Tile map
	typedef logic [9:0]  vram_addr_t;   // Row bits then column bits
	typedef logic [15:0] vram_word_t;   // 9..0 code, 10 palette bank

	// Tile ROM
	typedef logic [12:0] rom_addr_t;    // Tile code then row in tile
	typedef logic [31:0] rom_row_t;     // Eight 4-bit pixels, pixel 0 lowest

	// Palette and output
	typedef logic [4:0]  pal_idx_t;
	typedef logic [7:0]  pixel_t;

	// Screen position
	typedef logic [8:0]  coord_t;       // Pixel counter value
	typedef logic [7:0]  scroll_t;      // Wraps over the 256 pixel map

endpackage

// File: source/cpu_bus_if.sv
// Internal CPU bus between the address decoder and the video register block
`timescale 1ns/1ns

interface cpu_bus_if;

	arcade_pkg::cpu_addr_t cpu_adr;
	arcade_pkg::cpu_data_t wdat;
	logic                  rd;      // Single-cycle read strobe
	logic                  wr;      // Single-cycle write strobe
	logic                  sel;     // Address falls in VRAM or register window
	arcade_pkg::cpu_data_t rdat;    // Valid the cycle after the read edge

	modport main (
		output cpu_adr,
		output wdat,
		output rd,
		output wr,
		output sel,
		input  rdat
	);

	modport video (
		input  cpu_adr,
		input  wdat,
		input  rd,
		input  wr,
		input  sel,
		output rdat
	);

endinterface

// File: source/tile_vram.sv
// Background tile map RAM, 1024 words, byte writes from the CPU and a read-only video port
`timescale 1ns/1ns

module tile_vram (
	input  logic                   MCLK,
	input  arcade_pkg::vram_addr_t cpu_addr,
	input  logic                   cpu_hi,     // Selects the upper byte lane
	input  logic                   cpu_we,
	input  arcade_pkg::cpu_data_t  cpu_wdat,
	output arcade_pkg::vram_word_t cpu_rdat,
	input  arcade_pkg::vram_addr_t vid_addr,
	output arcade_pkg::vram_word_t vid_rdat
);

	localparam int depth = 1 << $bits(arcade_pkg::vram_addr_t);

	arcade_pkg::vram_word_t mem [depth];

	// CPU port, old word is returned on a write cycle
	always_ff @(posedge MCLK) begin
		if (cpu_we) begin
			if (cpu_hi)
				mem[cpu_addr][15:8] <= cpu_wdat;
			else
				mem[cpu_addr][7:0] <= cpu_wdat;
		end
		cpu_rdat <= mem[cpu_addr];
	end

	always_ff @(posedge MCLK) begin
		vid_rdat <= mem[vid_addr];         // Video port
	end

endmodule

// File: source/bg_tile_fetch.sv
// Scrolled background pipeline from pixel position to palette index via tile map and tile ROM
`timescale 1ns/1ns
`include "arcade_settings.svh"

module bg_tile_fetch (
	input  logic                   MCLK,
	input  logic                   rst_n,
	input  logic                   pclk_en,
	input  arcade_pkg::coord_t     ph,
	input  arcade_pkg::coord_t     pv,
	input  arcade_pkg::scroll_t    scroll_x,
	input  arcade_pkg::scroll_t    scroll_y,
	input  arcade_pkg::vram_word_t vram_rdat,
	input  arcade_pkg::rom_row_t   rom_data,
	output arcade_pkg::vram_addr_t vram_addr,
	output arcade_pkg::rom_addr_t  rom_addr,
	output arcade_pkg::pal_idx_t   pal_idx,
	output logic                   blank
);

	arcade_pkg::scroll_t x_sum, y_sum;
	logic [2:0]          fine_x, fine_y;
	logic                blank_s0;
	logic                bank;
	logic [1:0]          en_d;         // Strobe delayed by one and two clocks
	logic [3:0]          nibble;

	assign x_sum  = ph[7:0] + scroll_x;    // Wraps within the map
	assign y_sum  = pv[7:0] + scroll_y;
	assign nibble = rom_data[{fine_x, 2'b00} +: 4];

	// Strobe k, map lookup
	always_ff @(posedge MCLK) begin
		if (pclk_en) begin
			vram_addr <= {y_sum[7:3], x_sum[7:3]};
			fine_x    <= x_sum[2:0];
			fine_y    <= y_sum[2:0];
			blank_s0  <= pv >= arcade_pkg::coord_t'(`ARC_VBLANK_LINE);
		end
	end

	always_ff @(posedge MCLK or negedge rst_n) begin
		if (!rst_n) begin
			en_d     <= 2'b00;
			rom_addr <= '0;
			bank     <= 1'b0;
			pal_idx  <= '0;
			blank    <= 1'b0;
		end else begin
			en_d <= {en_d[0], pclk_en};
			if (en_d[1]) begin
				rom_addr <= {vram_rdat[9:0], fine_y};   // Map word is valid here
				bank     <= vram_rdat[10];
			end
			if (pclk_en) begin
				pal_idx <= {bank, nibble};           // Strobe k+1
				blank   <= blank_s0;
			end
		end
	end

endmodule

// File: source/palette_ram.sv
// 32-entry palette with an external load port and a blanked pixel output register
`timescale 1ns/1ns

module palette_ram (
	input  logic                 MCLK,
	input  logic                 rst_n,
	input  logic                 pclk_en,
	input  arcade_pkg::pal_idx_t pal_idx,
	input  logic                 blank,
	input  arcade_pkg::pal_idx_t wr_adr,
	input  logic                 wr,
	input  arcade_pkg::pixel_t   wr_dat,
	output arcade_pkg::pixel_t   pix_out
);

	arcade_pkg::pixel_t mem [1 << $bits(arcade_pkg::pal_idx_t)];

	always_ff @(posedge MCLK) begin
		if (wr)
			mem[wr_adr] <= wr_dat;
	end

	always_ff @(posedge MCLK or negedge rst_n) begin
		if (!rst_n)
			pix_out <= '0;
		else if (pclk_en)
			pix_out <= blank ? '0 : mem[pal_idx];   // Black during vertical blank
	end

endmodule

// File: source/arcade_io_video.sv
// Video block with pixel clock divider, scroll registers, CPU read data and the tile pipeline
`timescale 1ns/1ns
`include "arcade_settings.svh"

module arcade_io_video (
	input  logic                  MCLK,
	input  logic                  rst_n,
	input  arcade_pkg::coord_t    ph,
	input  arcade_pkg::coord_t    pv,
	input  arcade_pkg::rom_row_t  bg_rom_data,
	input  arcade_pkg::pal_idx_t  pal_adr,
	input  logic                  pal_wr,
	input  arcade_pkg::pixel_t    pal_dat,
	output logic                  pclk_en,
	output logic                  vblk,
	output arcade_pkg::pixel_t    pix_out,
	output arcade_pkg::rom_addr_t bg_rom_addr,
	cpu_bus_if.video              bus
);

	localparam arcade_pkg::cpu_addr_t reg_base   = `ARC_REG_BASE;
	localparam arcade_pkg::cpu_addr_t vram_limit = arcade_pkg::cpu_addr_t'(`ARC_VRAM_BYTES);

	logic [`ARC_PCLK_DIV_BITS-1:0] div_cnt;
	arcade_pkg::scroll_t           scroll_x, scroll_y;
	arcade_pkg::cpu_addr_t         rd_adr_q;
	arcade_pkg::vram_word_t        vram_cpu_rdat, vram_vid_rdat;
	arcade_pkg::vram_addr_t        vram_vid_addr;
	arcade_pkg::pal_idx_t          pal_idx;
	logic                          blank;
	logic                          vram_we;

	assign pclk_en = &div_cnt;             // Last count of each divider cycle
	assign vram_we = bus.wr && bus.sel && bus.cpu_adr < vram_limit;

	always_ff @(posedge MCLK or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt  <= '0;
			scroll_x <= '0;
			scroll_y <= '0;
			vblk     <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			if (bus.wr && bus.sel && bus.cpu_adr == reg_base)
				scroll_x <= bus.wdat;
			if (bus.wr && bus.sel && bus.cpu_adr == reg_base + 16'd1)
				scroll_y <= bus.wdat;
			if (pclk_en)
				vblk <= pv >= arcade_pkg::coord_t'(`ARC_VBLANK_LINE);
		end
	end

	// VRAM word arrives one cycle after the read edge, byte picked the cycle after
	always_ff @(posedge MCLK) begin
		if (bus.rd)
			rd_adr_q <= bus.cpu_adr;
		if (rd_adr_q < vram_limit)
			bus.rdat <= rd_adr_q[0] ? vram_cpu_rdat[15:8] : vram_cpu_rdat[7:0];
		else if (rd_adr_q == reg_base)
			bus.rdat <= scroll_x;
		else if (rd_adr_q == reg_base + 16'd1)
			bus.rdat <= scroll_y;
		else
			bus.rdat <= 8'hFF;
	end

	tile_vram tile_vram (
		.MCLK     (MCLK),
		.cpu_addr (bus.cpu_adr[10:1]),
		.cpu_hi   (bus.cpu_adr[0]),
		.cpu_we   (vram_we),
		.cpu_wdat (bus.wdat),
		.cpu_rdat (vram_cpu_rdat),
		.vid_addr (vram_vid_addr),
		.vid_rdat (vram_vid_rdat)
	);

	bg_tile_fetch bg_tile_fetch (
		.MCLK      (MCLK),
		.rst_n     (rst_n),
		.pclk_en   (pclk_en),
		.ph        (ph),
		.pv        (pv),
		.scroll_x  (scroll_x),
		.scroll_y  (scroll_y),
		.vram_rdat (vram_vid_rdat),
		.rom_data  (bg_rom_data),
		.vram_addr (vram_vid_addr),
		.rom_addr  (bg_rom_addr),
		.pal_idx   (pal_idx),
		.blank     (blank)
	);

	palette_ram palette_ram (
		.MCLK    (MCLK),
		.rst_n   (rst_n),
		.pclk_en (pclk_en),
		.pal_idx (pal_idx),
		.blank   (blank),
		.wr_adr  (pal_adr),
		.wr      (pal_wr),
		.wr_dat  (pal_dat),
		.pix_out (pix_out)
	);

endmodule

// File: source/arcade_main.sv
// CPU bus decoder with control panel and DIP switch reads and a two-stage read return
`timescale 1ns/1ns
`include "arcade_settings.svh"

module arcade_main (
	input  logic                  MCLK,
	input  logic                  rst_n,
	input  arcade_pkg::cpu_addr_t cpu_adr,
	input  arcade_pkg::cpu_data_t cpu_wdat,
	input  logic                  cpu_wr,
	input  logic                  cpu_rd,
	input  arcade_pkg::cpu_data_t ctr1,
	input  arcade_pkg::cpu_data_t dsw1,
	input  logic                  vblk,
	output arcade_pkg::cpu_data_t cpu_rdat,
	output logic                  cpu_rvld,
	cpu_bus_if.main               bus
);

	localparam arcade_pkg::cpu_addr_t reg_base   = `ARC_REG_BASE;
	localparam arcade_pkg::cpu_addr_t vram_limit = arcade_pkg::cpu_addr_t'(`ARC_VRAM_BYTES);

	// Read source classes
	localparam logic [2:0] cls_bus    = 3'd0;
	localparam logic [2:0] cls_status = 3'd1;
	localparam logic [2:0] cls_ctr1   = 3'd2;
	localparam logic [2:0] cls_dsw1   = 3'd3;
	localparam logic [2:0] cls_none   = 3'd4;

	logic [2:0] cls;
	logic [2:0] cls_s1, cls_s2;
	logic       rd_s1, rd_s2;

	assign bus.cpu_adr = cpu_adr;
	assign bus.wdat    = cpu_wdat;
	assign bus.rd      = cpu_rd;
	assign bus.wr      = cpu_wr;
	assign bus.sel     = cpu_adr < reg_base + 16'd8;

	always_comb begin
		if (cpu_adr < vram_limit || cpu_adr == reg_base || cpu_adr == reg_base + 16'd1)
			cls = cls_bus;                         // Served by the video block
		else if (cpu_adr == reg_base + 16'd2)
			cls = cls_status;
		else if (cpu_adr == reg_base + 16'd3)
			cls = cls_ctr1;
		else if (cpu_adr == reg_base + 16'd4)
			cls = cls_dsw1;
		else
			cls = cls_none;
	end

	always_ff @(posedge MCLK or negedge rst_n) begin
		if (!rst_n) begin
			rd_s1    <= 1'b0;
			rd_s2    <= 1'b0;
			cpu_rvld <= 1'b0;
		end else begin
			rd_s1    <= cpu_rd;
			rd_s2    <= rd_s1;
			cpu_rvld <= rd_s2;
		end
	end

	always_ff @(posedge MCLK) begin
		cls_s1 <= cls;
		cls_s2 <= cls_s1;                      // Lines up with bus.rdat
		if (rd_s2) begin
			case (cls_s2)
				cls_bus:    cpu_rdat <= bus.rdat;
				cls_status: cpu_rdat <= {7'd0, vblk};
				cls_ctr1:   cpu_rdat <= ctr1;
				cls_dsw1:   cpu_rdat <= dsw1;
				default:    cpu_rdat <= 8'hFF;     // Unmapped
			endcase
		end
	end

endmodule

// File: source/arcade_top.sv
// Arcade video and I/O subsystem top level joining the bus decoder and the video block
`timescale 1ns/1ns

module arcade_top (
	input  logic                  MCLK,         // Master clock
	input  logic                  rst_n,
	input  arcade_pkg::cpu_addr_t cpu_adr,      // External CPU bus
	input  arcade_pkg::cpu_data_t cpu_wdat,
	input  logic                  cpu_wr,
	input  logic                  cpu_rd,
	output arcade_pkg::cpu_data_t cpu_rdat,
	output logic                  cpu_rvld,
	input  arcade_pkg::cpu_data_t ctr1,         // Control panel
	input  arcade_pkg::cpu_data_t dsw1,         // DIP switches
	input  arcade_pkg::coord_t    ph,           // Pixel H
	input  arcade_pkg::coord_t    pv,           // Pixel V
	output logic                  pclk_en,      // Pixel clock enable
	output arcade_pkg::pixel_t    pix_out,
	output logic                  vblk,
	output arcade_pkg::rom_addr_t bg_rom_addr,  // Background tile ROM
	input  arcade_pkg::rom_row_t  bg_rom_data,
	input  arcade_pkg::pal_idx_t  pal_adr,      // Palette load port
	input  logic                  pal_wr,
	input  arcade_pkg::pixel_t    pal_dat
);

	cpu_bus_if bus ();

	arcade_main arcade_main (
		.MCLK     (MCLK),
		.rst_n    (rst_n),
		.cpu_adr  (cpu_adr),
		.cpu_wdat (cpu_wdat),
		.cpu_wr   (cpu_wr),
		.cpu_rd   (cpu_rd),
		.ctr1     (ctr1),
		.dsw1     (dsw1),
		.vblk     (vblk),
		.cpu_rdat (cpu_rdat),
		.cpu_rvld (cpu_rvld),
		.bus      (bus.main)
	);

	arcade_io_video arcade_io_video (
		.MCLK        (MCLK),
		.rst_n       (rst_n),
		.ph          (ph),
		.pv          (pv),
		.bg_rom_data (bg_rom_data),
		.pal_adr     (pal_adr),
		.pal_wr      (pal_wr),
		.pal_dat     (pal_dat),
		.pclk_en     (pclk_en),
		.vblk        (vblk),
		.pix_out     (pix_out),
		.bg_rom_addr (bg_rom_addr),
		.bus         (bus.video)
	);

endmodule

// File: test/tb_arcade_top.sv
// Testbench for the arcade video subsystem with a tile ROM model and directed checks
`timescale 1ns/1ns
`include "arcade_settings.svh"

module tb_arcade_top;

	logic MCLK = 1'b0;
	logic rst_n;
	arcade_pkg::cpu_addr_t cpu_adr;
	arcade_pkg::cpu_data_t cpu_wdat, cpu_rdat, ctr1, dsw1;
	logic cpu_wr, cpu_rd, cpu_rvld, pclk_en, vblk, pal_wr;
	arcade_pkg::coord_t ph, pv;
	arcade_pkg::pixel_t pix_out, pal_dat;
	arcade_pkg::rom_addr_t bg_rom_addr;
	arcade_pkg::rom_row_t bg_rom_data = '0;
	arcade_pkg::pal_idx_t pal_adr;

	logic [15:0] lfsr_state = 16'd46596;
	logic [7:0] vram_model [2048];     // CPU byte view of the tile map
	logic [7:0] pal_model [32];
	logic [7:0] sx = 8'd0, sy = 8'd0;
	int err_cnt = 0, to_cnt = 0;

	arcade_top DUT (.*);

	initial forever #2 MCLK = ~MCLK;

	// Tile ROM, nibble n of a row is the low 4 bits of address + n
	always @(posedge MCLK) begin
		for (int n = 0; n < 8; n++)
			bg_rom_data[4*n +: 4] <= 4'(bg_rom_addr + 13'(n));
	end

	// Galois LFSR, one step for each bit taken
	function automatic logic [15:0] get_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
		end
		get_bits = v;
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		err_cnt++;
		$display("ERR %0t %s expected %0h actual %0h", $time, name, exp, got);
	endtask

	task automatic wait_pclk(output int n);
		n = 0;
		do begin
			@(posedge MCLK);
			n++;
		end while (!pclk_en && n < 20);
		if (!pclk_en) begin
			to_cnt++;
			$display("Timeout: no pclk_en pulse within 20 cycles");
		end
	endtask

	task automatic wait_rvld(output int n);
		n = 0;
		do begin
			@(posedge MCLK);
			n++;
		end while (!cpu_rvld && n < 10);
		if (!cpu_rvld) begin
			to_cnt++;
			$display("Timeout: cpu_rvld did not rise within 10 cycles of a read");
		end
	endtask

	task automatic cpu_write(input arcade_pkg::cpu_addr_t a, input arcade_pkg::cpu_data_t d);
		@(posedge MCLK);
		cpu_adr <= a;
		cpu_wdat <= d;
		cpu_wr <= 1'b1;
		@(posedge MCLK);
		cpu_wr <= 1'b0;
		if (a < `ARC_VRAM_BYTES)
			vram_model[a[10:0]] = d;
		else if (a == `ARC_REG_BASE)
			sx = d;
		else if (a == `ARC_REG_BASE + 16'd1)
			sy = d;
	endtask

	task automatic read_expect(input arcade_pkg::cpu_addr_t a, input arcade_pkg::cpu_data_t exp);
		int n;
		@(posedge MCLK);
		cpu_adr <= a;
		cpu_rd <= 1'b1;
		@(posedge MCLK);                        // Edge t samples the strobe
		cpu_rd <= 1'b0;
		wait_rvld(n);
		if (cpu_rvld && n != 3)
			report_value("cpu_rvld latency", 3, n);   // High after t+2, seen at t+3
		if (cpu_rvld && cpu_rdat !== exp)
			report_value("cpu_rdat", exp, cpu_rdat);
	endtask

	task automatic read_pair(input arcade_pkg::cpu_addr_t a, input arcade_pkg::cpu_data_t ea,
			input arcade_pkg::cpu_addr_t b, input arcade_pkg::cpu_data_t eb);
		int n;
		@(posedge MCLK);
		cpu_adr <= a;
		cpu_rd <= 1'b1;
		@(posedge MCLK);
		cpu_adr <= b;
		@(posedge MCLK);
		cpu_rd <= 1'b0;
		wait_rvld(n);
		if (cpu_rvld && cpu_rdat !== ea)
			report_value("cpu_rdat", ea, cpu_rdat);
		@(posedge MCLK);
		if (cpu_rvld !== 1'b1)
			report_value("cpu_rvld", 1, cpu_rvld);
		if (cpu_rdat !== eb)
			report_value("cpu_rdat", eb, cpu_rdat);
	endtask

	function automatic arcade_pkg::pixel_t predict_pixel(input arcade_pkg::coord_t h,
			input arcade_pkg::coord_t v, output arcade_pkg::rom_addr_t row);
		logic [7:0] x, y;
		logic [9:0] idx;
		logic [15:0] word;
		logic [3:0] nib;
		x = h[7:0] + sx;
		y = v[7:0] + sy;
		idx = {y[7:3], x[7:3]};
		word = {vram_model[{idx, 1'b1}], vram_model[{idx, 1'b0}]};
		row = {word[9:0], y[2:0]};
		nib = row[3:0] + {1'b0, x[2:0]};   // Low nibble of ROM address + x
		if (v >= `ARC_VBLANK_LINE)
			predict_pixel = '0;
		else
			predict_pixel = pal_model[{word[10], nib}];
	endfunction

	task automatic check_pclk;
		int n;
		wait_pclk(n);
		if (n != 8)
			report_value("pclk_en first pulse", 8, n);
		for (int i = 0; i < 4; i++) begin
			wait_pclk(n);
			if (n != 8)
				report_value("pclk_en period", 8, n);
		end
	endtask

	task automatic load_palette;
		logic [15:0] r;
		for (int i = 0; i < 32; i++) begin
			r = get_bits(8);
			@(posedge MCLK);
			pal_adr <= 5'(i);
			pal_dat <= r[7:0];
			pal_wr <= 1'b1;
			pal_model[i] = r[7:0];
		end
		@(posedge MCLK);
		pal_wr <= 1'b0;
	endtask

	task automatic fill_vram;
		logic [15:0] r;
		for (int a = 0; a < `ARC_VRAM_BYTES; a++) begin
			r = get_bits(8);
			cpu_write(16'(a), r[7:0]);
		end
	endtask

	// Overwrite one byte and confirm the other lane of the word is untouched
	task automatic vram_readback;
		logic [15:0] r;
		logic [10:0] a;
		for (int i = 0; i < 12; i++) begin
			r = get_bits(11);
			a = r[10:0];
			r = get_bits(8);
			cpu_write({5'd0, a}, r[7:0]);
			read_expect({5'd0, a}, vram_model[a]);
			read_expect({5'd0, a ^ 11'd1}, vram_model[a ^ 11'd1]);
		end
	endtask

	task automatic check_registers;
		logic [15:0] r;
		r = get_bits(16);
		@(posedge MCLK);
		ctr1 <= r[7:0];
		dsw1 <= r[15:8];
		cpu_write(`ARC_REG_BASE, 8'h5B);
		cpu_write(`ARC_REG_BASE + 16'd1, 8'hA7);
		read_expect(`ARC_REG_BASE, 8'h5B);
		read_expect(`ARC_REG_BASE + 16'd1, 8'hA7);
		read_expect(`ARC_REG_BASE + 16'd3, r[7:0]);
		read_expect(`ARC_REG_BASE + 16'd4, r[15:8]);
		read_expect(`ARC_REG_BASE + 16'd7, 8'hFF);
		read_expect(16'h1234, 8'hFF);
		read_pair(`ARC_REG_BASE + 16'd1, 8'hA7, `ARC_REG_BASE + 16'd4, r[15:8]);
		read_pair(16'h0123, vram_model[11'h123], `ARC_REG_BASE + 16'd3, r[7:0]);
	endtask

	// Pixel driven at strobe j is sampled at j+1, ROM address and vblk checked at j+2,
	// pix_out at j+4
	task automatic render(input int n, input int v_lo, input int v_span);
		arcade_pkg::pixel_t exp_pix [64];
		arcade_pkg::rom_addr_t exp_rom [64];
		logic exp_vb [64];
		logic [15:0] r;
		arcade_pkg::coord_t h, v;
		arcade_pkg::rom_addr_t row;
		int gap;
		for (int j = 0; j < n + 4; j++) begin
			wait_pclk(gap);
			if (j >= 4 && pix_out !== exp_pix[j-4])
				report_value("pix_out", exp_pix[j-4], pix_out);
			if (j >= 2 && j - 2 < n && vblk !== exp_vb[j-2])
				report_value("vblk", exp_vb[j-2], vblk);
			if (j >= 2 && j - 2 < n && bg_rom_addr !== exp_rom[j-2])
				report_value("bg_rom_addr", exp_rom[j-2], bg_rom_addr);
			if (j < n) begin
				r = get_bits(9);
				h = r[8:0];
				r = get_bits(9);
				v = arcade_pkg::coord_t'(v_lo + int'(r[8:0]) % v_span);
				ph <= h;
				pv <= v;
				exp_pix[j] = predict_pixel(h, v, row);
				exp_rom[j] = row;
				exp_vb[j] = v >= `ARC_VBLANK_LINE;
			end
		end
	endtask

	task automatic check_vblank;
		int gap;
		@(posedge MCLK);
		pv <= 9'd240;
		wait_pclk(gap);
		wait_pclk(gap);
		read_expect(`ARC_REG_BASE + 16'd2, 8'h01);
		render(12, `ARC_VBLANK_LINE, 512 - `ARC_VBLANK_LINE);
		render(12, 0, `ARC_VBLANK_LINE);   // Back in the visible lines
		read_expect(`ARC_REG_BASE + 16'd2, 8'h00);
	endtask

	initial begin
		rst_n = 1'b0;
		cpu_adr = '0;
		cpu_wdat = '0;
		cpu_wr = 1'b0;
		cpu_rd = 1'b0;
		ctr1 = '0;
		dsw1 = '0;
		ph = '0;
		pv = '0;
		pal_adr = '0;
		pal_wr = 1'b0;
		pal_dat = '0;
		repeat (10) @(posedge MCLK);
		rst_n <= 1'b1;
		check_pclk;
		load_palette;
		fill_vram;
		vram_readback;
		render(24, 0, `ARC_VBLANK_LINE);   // Scrolls still zero
		check_registers;
		render(24, 0, `ARC_VBLANK_LINE);   // Scrolled
		check_vblank;
		$display("Errors: %0d value, %0d timeout", err_cnt, to_cnt);
		if (err_cnt == 0 && to_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: project.f
+incdir+source
source/arcade_pkg.sv
source/cpu_bus_if.sv
source/tile_vram.sv
source/bg_tile_fetch.sv
source/palette_ram.sv
source/arcade_io_video.sv
source/arcade_main.sv
source/arcade_top.sv
test/tb_arcade_top.sv

// File: Makefile
TOP := tb_arcade_top

all: run

build:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module arcade_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
